// ==== logic/mems_pkg.sv ====
package mems_pkg;

  // uart bit timing, in clk cycles
  localparam int clks_per_bit = 16;

  // spi clock, half period in clk cycles
  localparam int spi_half = 2;
  localparam int frame_bits = 24;

  // waveform table layout
  localparam int rom_depth = 482;
  localparam int addr_first_ch = 2;
  localparam int addr_last = 481;

  typedef logic [8:0] rom_addr_t;

  // one dac frame as it goes out on the wire, msb first
  typedef struct packed {
    logic [3:0]  cmd;
    logic [3:0]  chan;
    logic [15:0] value;
  } dac_frame_t;

  // dac command codes in the top nibble
  typedef enum logic [3:0] {
    dac_write_upd  = 4'd3,
    dac_ldac_setup = 4'd6,
    dac_soft_reset = 4'd7
  } dac_cmd_e;

  typedef enum logic [1:0] {idle, soft_reset, ldac_setup, stream} seq_state_e;
  typedef enum logic [1:0] {ch_a, ch_b, ch_c, ch_d} chan_e;

  // received byte plus its one-cycle strobe
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } uart_byte_t;

  // operator command bytes, ascii h p s
  localparam logic [7:0] cmd_halt_init = 8'h68;
  localparam logic [7:0] cmd_play = 8'h70;
  localparam logic [7:0] cmd_stop = 8'h73;

  // table content for one address, zero past the end
  function automatic dac_frame_t rom_word(input int unsigned a);
    dac_frame_t f;
    int unsigned k;
    int unsigned c;
    int unsigned v;
    f = '0;
    if (a == 0) begin
      f.cmd = dac_soft_reset;
    end else if (a == 1) begin
      f.cmd = dac_ldac_setup;
      f.value = 16'd1;
    end else if (a < rom_depth) begin
      // four channel frames per step, channel offset a quarter of full scale
      k = (a - addr_first_ch) / 4;
      c = (a - addr_first_ch) % 4;
      v = k * 546 + c * 16384;
      f.cmd = dac_write_upd;
      f.chan = c[3:0];
      f.value = v[15:0];
    end
    return f;
  endfunction

endpackage

// ==== logic/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output uart_byte_t rx_byte
);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

  rx_state_e state;
  logic rxd_meta;
  logic rxd_sync;
  logic [$clog2(clks_per_bit)-1:0] cnt;
  logic [2:0] bit_idx;
  logic [7:0] shreg;
  logic [7:0] data_q;
  logic valid_q;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
      cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        rx_idle: begin
          cnt <= '0;
          bit_idx <= '0;
          // falling edge marks a start bit
          if (!rxd_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          cnt <= cnt + 1'b1;
          // half a bit in, recheck so a glitch is not taken as a start
          if (int'(cnt) == clks_per_bit / 2 - 1) begin
            cnt <= '0;
            state <= rxd_sync ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          cnt <= cnt + 1'b1;
          if (int'(cnt) == clks_per_bit - 1) begin
            cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          cnt <= cnt + 1'b1;
          if (int'(cnt) == clks_per_bit - 1) begin
            // framing error drops the byte
            valid_q <= rxd_sync;
            state <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // lsb first, shift in at each mid-bit sample
  always_ff @(posedge clk) begin
    if (state == rx_data && int'(cnt) == clks_per_bit - 1) begin
      shreg <= {rxd_sync, shreg[7:1]};
    end
    if (state == rx_stop && int'(cnt) == clks_per_bit - 1) begin
      data_q <= shreg;
    end
  end

  assign rx_byte = '{data: data_q, valid: valid_q};

endmodule

// ==== logic/mems_rom.sv ====
`timescale 1ns/10ps

module mems_rom
  import mems_pkg::*;
(
  input  logic       clk,
  input  rom_addr_t  addr,
  output dac_frame_t data
);

  // table storage
  // word 0 soft reset, word 1 ldac setup, the rest channel frames
  dac_frame_t mem [rom_depth];

  // contents come from the package rule
  initial begin
    for (int i = 0; i < rom_depth; i++) begin
      mem[i] = rom_word(i);
    end
  end

  // registered read, one cycle latency
  // out-of-range addresses return an all-zero frame
  always_ff @(posedge clk) begin
    if (addr < rom_addr_t'(rom_depth)) begin
      data <= mem[addr];
    end else begin
      data <= '0;
    end
  end

endmodule

// ==== logic/mems_control.sv ====
`timescale 1ns/10ps

module mems_control
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  uart_byte_t rx_byte,
  input  logic       spi_busy,
  output logic       spi_start,
  output dac_frame_t frame_word
);

  seq_state_e state_q;
  seq_state_e state_next;
  chan_e chan_q;
  chan_e chan_next;
  rom_addr_t addr_q;
  rom_addr_t addr_next;
  logic start_q;
  logic start_next;

  // decoded command strobes
  logic got_halt_init;
  logic got_play;
  logic got_stop;
  // engine free and no start still in flight
  logic spi_ready;

  assign got_halt_init = rx_byte.valid && rx_byte.data == cmd_halt_init;
  assign got_play = rx_byte.valid && rx_byte.data == cmd_play;
  assign got_stop = rx_byte.valid && rx_byte.data == cmd_stop;
  assign spi_ready = !spi_busy && !start_q;

  assign spi_start = start_q;

  // rom follows addr_q, word is ready one cycle after the start
  mems_rom u_rom (
    .clk  (clk),
    .addr (addr_q),
    .data (frame_word)
  );

  always_comb begin
    state_next = state_q;
    chan_next = chan_q;
    addr_next = addr_q;
    start_next = 1'b0;

    case (state_q)
      idle: begin
        addr_next = '0;
        if (got_halt_init) begin
          // frame 0 goes out right away
          state_next = soft_reset;
          start_next = 1'b1;
        end else if (got_play) begin
          // straight to channel frames, no init
          state_next = stream;
          chan_next = ch_a;
          addr_next = rom_addr_t'(addr_first_ch);
          start_next = 1'b1;
        end
      end

      soft_reset: begin
        if (spi_ready) begin
          addr_next = addr_q + 1'b1;
          state_next = ldac_setup;
          start_next = 1'b1;
        end
      end

      ldac_setup: begin
        if (spi_ready) begin
          // first channel frame, address 2
          addr_next = addr_q + 1'b1;
          state_next = stream;
          chan_next = ch_a;
          start_next = 1'b1;
        end
      end

      stream: begin
        // chan_q is the channel of the frame last started
        if (spi_ready) begin
          start_next = 1'b1;
          addr_next = addr_q + 1'b1;
          case (chan_q)
            ch_a: chan_next = ch_b;
            ch_b: chan_next = ch_c;
            ch_c: chan_next = ch_d;
            ch_d: begin
              chan_next = ch_a;
              // end of table, back to first channel frame
              if (addr_q == rom_addr_t'(addr_last)) begin
                addr_next = rom_addr_t'(addr_first_ch);
              end
            end
            default: chan_next = ch_a;
          endcase
        end
      end

      default: state_next = idle;
    endcase

    // stop wins over everything, a frame in flight still finishes
    if (got_stop) begin
      state_next = idle;
      addr_next = '0;
      start_next = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= idle;
      chan_q <= ch_a;
      addr_q <= '0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_next;
      chan_q <= chan_next;
      addr_q <= addr_next;
      start_q <= start_next;
    end
  end

endmodule

// ==== logic/spi_master.sv ====
`timescale 1ns/10ps

module spi_master
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  dac_frame_t word,
  output logic       busy,
  output logic       sclk,
  output logic       mosi,
  output logic       sync_n
);

  typedef enum logic [1:0] {spi_idle, spi_load, spi_shift, spi_gap} spi_state_e;

  spi_state_e state;
  logic [$clog2(spi_half)-1:0] half_cnt;
  logic [$clog2(frame_bits)-1:0] bit_cnt;
  logic [frame_bits-1:0] shreg;
  logic [frame_bits-1:0] word_bits;

  assign word_bits = word;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= spi_idle;
      busy <= 1'b0;
      sclk <= 1'b0;
      mosi <= 1'b0;
      sync_n <= 1'b1;
      half_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        spi_idle: begin
          if (start) begin
            busy <= 1'b1;
            state <= spi_load;
          end
        end
        spi_load: begin
          // rom word is valid now, frame begins next cycle
          sync_n <= 1'b0;
          mosi <= word_bits[frame_bits-1];
          half_cnt <= '0;
          bit_cnt <= '0;
          state <= spi_shift;
        end
        spi_shift: begin
          half_cnt <= half_cnt + 1'b1;
          if (int'(half_cnt) == spi_half - 1) begin
            half_cnt <= '0;
            sclk <= !sclk;
            // falling edge, move to the next bit
            if (sclk) begin
              if (int'(bit_cnt) == frame_bits - 1) begin
                sync_n <= 1'b1;
                mosi <= 1'b0;
                state <= spi_gap;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                mosi <= shreg[frame_bits-2];
              end
            end
          end
        end
        spi_gap: begin
          // inter-frame gap, busy held
          half_cnt <= half_cnt + 1'b1;
          if (int'(half_cnt) == spi_half - 1) begin
            half_cnt <= '0;
            busy <= 1'b0;
            state <= spi_idle;
          end
        end
        default: state <= spi_idle;
      endcase
    end
  end

  // data shift register, msb leaves first
  always_ff @(posedge clk) begin
    if (state == spi_load) begin
      shreg <= word_bits;
    end else if (state == spi_shift && int'(half_cnt) == spi_half - 1 && sclk) begin
      shreg <= {shreg[frame_bits-2:0], 1'b0};
    end
  end

endmodule

// ==== logic/mems_top.sv ====
`timescale 1ns/10ps

module mems_top
  import mems_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic uart_rxd,
  output logic spi_sclk,
  output logic spi_mosi,
  output logic spi_sync_n
);

  // command bytes from the operator line
  uart_byte_t rx_byte;
  // frame handoff between sequencer and spi engine
  dac_frame_t frame_word;
  logic spi_start;
  logic spi_busy;

  uart_rx u_uart_rx (
    .clk     (clk),
    .rst     (rst),
    .rxd     (uart_rxd),
    .rx_byte (rx_byte)
  );

  // sequencer, holds the waveform rom
  mems_control u_control (
    .clk        (clk),
    .rst        (rst),
    .rx_byte    (rx_byte),
    .spi_busy   (spi_busy),
    .spi_start  (spi_start),
    .frame_word (frame_word)
  );

  spi_master u_spi (
    .clk    (clk),
    .rst    (rst),
    .start  (spi_start),
    .word   (frame_word),
    .busy   (spi_busy),
    .sclk   (spi_sclk),
    .mosi   (spi_mosi),
    .sync_n (spi_sync_n)
  );

endmodule

// ==== test/mems_checker.sv ====
`timescale 1ns/10ps

module mems_checker
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       sclk,
  input  logic       mosi,
  input  logic       sync_n,
  input  logic       cmd_valid,
  input  logic [7:0] cmd_byte,
  output int         frame_count,
  output int         error_count
);

  // stream running as far as the sent commands go
  logic active;
  // one frame still allowed after a stop
  logic grace;
  int next_addr;
  logic [frame_bits-1:0] shreg;
  int nbits;
  logic sclk_q;
  logic sync_q;
  // clk cycles since the last rising sclk
  int since_rise;

  // table rule: reset frame, ldac frame, then four channels per step
  function automatic logic [23:0] expected_frame(input int a);
    int k;
    int c;
    logic [31:0] v;
    if (a == 0) begin
      return {4'd7, 4'd0, 16'd0};
    end
    if (a == 1) begin
      return {4'd6, 4'd0, 16'd1};
    end
    k = (a - 2) / 4;
    c = (a - 2) % 4;
    // channel offset a quarter of full scale, wraps at 16 bits
    v = k * 546 + c * 16384;
    return {4'd3, c[3:0], v[15:0]};
  endfunction

  // last table word wraps to channel a of step 0
  function automatic int step_addr(input int a);
    return (a == 481) ? 2 : a + 1;
  endfunction

  task automatic compare_frame();
    logic [23:0] exp;
    if (nbits != frame_bits) begin
      $display("at %0t an spi frame ended after %0d bits instead of %0d",
               $time, nbits, frame_bits);
      error_count++;
    end else if (!active && !grace) begin
      $display("at %0t spi frame %06h went out while no stream was running", $time, shreg);
      error_count++;
    end else begin
      exp = expected_frame(next_addr);
      if (shreg !== exp) begin
        $display("ERROR at %0t: spi frame expected %06h, got %06h", $time, exp, shreg);
        error_count++;
      end
      next_addr = step_addr(next_addr);
      grace = 1'b0;
    end
    frame_count++;
  endtask

  // h and p only count from idle, s always stops
  task automatic note_command(input logic [7:0] b);
    case (b)
      cmd_halt_init: begin
        if (!active) begin
          active = 1'b1;
          grace = 1'b0;
          next_addr = 0;
        end
      end
      cmd_play: begin
        if (!active) begin
          active = 1'b1;
          grace = 1'b0;
          next_addr = 2;
        end
      end
      cmd_stop: begin
        grace = active;
        active = 1'b0;
      end
      default: ;
    endcase
  endtask

  // pins read before this edge's updates land
  always @(posedge clk) begin
    if (rst) begin
      active = 1'b0;
      grace = 1'b0;
      next_addr = 0;
      shreg = '0;
      nbits = 0;
      sclk_q = 1'b0;
      sync_q = 1'b1;
      since_rise = 0;
      frame_count = 0;
      error_count = 0;
    end else begin
      since_rise = since_rise + 1;
      // dac latches on rising sclk inside the frame
      if (!sync_n && sclk && !sclk_q) begin
        // one sclk period is two half periods
        if (nbits > 0 && since_rise != 2 * spi_half) begin
          $display("ERROR at %0t: sclk period expected %0d, got %0d cycles",
                   $time, 2 * spi_half, since_rise);
          error_count++;
        end
        since_rise = 0;
        shreg = {shreg[frame_bits-2:0], mosi};
        nbits = nbits + 1;
      end
      // sync_n rising closes the frame
      if (sync_n && !sync_q) begin
        compare_frame();
        nbits = 0;
      end
      if (cmd_valid) begin
        note_command(cmd_byte);
      end
      sclk_q = sclk;
      sync_q = sync_n;
    end
  end

endmodule

// ==== test/mems_tb.sv ====
`timescale 1ns/10ps

module mems_tb
  import mems_pkg::*;
();

  // frames waited for over all tests, bytes sent over all tests
  localparam int frames_expected = 500 + 8 + 1 + 12;
  localparam int bytes_sent = 11;
  localparam int byte_cycles = 10 * clks_per_bit + 64;
  // 3004 covers reset and the two quiet windows
  localparam int watchdog_cycles =
    3004 + frames_expected * 120 + bytes_sent * byte_cycles * 2;

  logic clk = 1'b0;
  logic rst;
  logic uart_rxd;
  logic spi_sclk;
  logic spi_mosi;
  logic spi_sync_n;
  logic cmd_valid;
  logic [7:0] cmd_byte;
  int frame_count;
  int error_count;
  logic [31:0] lfsr;
  int tests_passed;
  int tests_failed;
  int errs;
  logic ok;
  logic [7:0] junk;

  always #10 clk = ~clk;

  mems_top dut (
    .clk        (clk),
    .rst        (rst),
    .uart_rxd   (uart_rxd),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_sync_n (spi_sync_n)
  );

  // told only which bytes went out
  mems_checker chk (
    .clk         (clk),
    .rst         (rst),
    .sclk        (spi_sclk),
    .mosi        (spi_mosi),
    .sync_n      (spi_sync_n),
    .cmd_valid   (cmd_valid),
    .cmd_byte    (cmd_byte),
    .frame_count (frame_count),
    .error_count (error_count)
  );

  // galois lfsr, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | lfsr[0];
    end
  endtask

  // anything but h, p and s
  task automatic random_junk_byte(output logic [7:0] b);
    int unsigned r;
    do begin
      random_bits(8, r);
      b = r[7:0];
    end while (b == cmd_halt_init || b == cmd_play || b == cmd_stop);
  endtask

  task automatic idle_gap();
    int unsigned g;
    random_bits(6, g);
    repeat (g) @(negedge clk);
  endtask

  // 8n1 lsb first, checker hears the byte once the stop bit is done
  task automatic send_uart_byte(input logic [7:0] b);
    @(negedge clk);
    uart_rxd = 1'b0;
    repeat (clks_per_bit) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      uart_rxd = b[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    uart_rxd = 1'b1;
    repeat (clks_per_bit) @(negedge clk);
    cmd_byte = b;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_count + n;
    while (frame_count < target) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input logic pass_ok, input int errs_before);
    if (pass_ok && error_count == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail", name);
    end
  endtask

  initial begin
    lfsr = 32'h8266_d2ff;
    rst = 1'b1;
    uart_rxd = 1'b1;
    cmd_valid = 1'b0;
    cmd_byte = '0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // nothing sent, pins must stay quiet
    errs = error_count;
    ok = 1'b1;
    repeat (2000) begin
      @(negedge clk);
      if (!spi_sync_n || spi_sclk) begin
        ok = 1'b0;
      end
    end
    if (!ok) begin
      $display("spi pins moved after reset with no command sent");
    end
    finish_test("idle after reset", ok, errs);

    // init frames then channel frames
    errs = error_count;
    send_uart_byte(cmd_halt_init);
    wait_frames(20);
    finish_test("init and stream start", 1'b1, errs);

    // run past address 481 and back to 2
    errs = error_count;
    wait_frames(480);
    finish_test("table wrap over 500 frames", 1'b1, errs);

    errs = error_count;
    for (int i = 0; i < 6; i++) begin
      random_junk_byte(junk);
      send_uart_byte(junk);
      idle_gap();
    end
    send_uart_byte(cmd_halt_init);
    idle_gap();
    send_uart_byte(cmd_play);
    wait_frames(8);
    finish_test("junk and repeated commands while streaming", 1'b1, errs);

    // frame in flight may finish, then silence
    errs = error_count;
    send_uart_byte(cmd_stop);
    while (!spi_sync_n) @(negedge clk);
    ok = 1'b1;
    repeat (1000) begin
      @(negedge clk);
      if (!spi_sync_n) begin
        ok = 1'b0;
      end
    end
    if (!ok) begin
      $display("sync_n went low again after the stop command");
    end
    finish_test("stop", ok, errs);

    errs = error_count;
    send_uart_byte(cmd_play);
    wait_frames(12);
    finish_test("play from idle", 1'b1, errs);

    $display("tests passed %0d, failed %0d, frame errors %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== mems_dac.f ====
logic/mems_pkg.sv
logic/uart_rx.sv
logic/mems_rom.sv
logic/mems_control.sv
logic/spi_master.sv
logic/mems_top.sv
test/mems_checker.sv
test/mems_tb.sv
